// ==== include/rf_cfg.svh ====
`ifndef RF_CFG_SVH
`define RF_CFG_SVH

// ==============================
// register file sizing
// ==============================

// hardware threads sharing the file, one bank each
`define RF_NTHREADS 4

// registers per thread, reg 0 is hardwired zero
`define RF_NREGS 64

// width of one register value
`define RF_VALUE_W 32

// flat address is thread above register
// so both counts must stay powers of two

`endif

// ==== logic/rfPkg.sv ====
`include "rf_cfg.svh"

package rfPkg;

  // ==============================
  // vector types
  // ==============================
  typedef logic [`RF_VALUE_W-1:0]            value_t;    // one register value
  typedef logic [$clog2(`RF_NREGS)-1:0]      regIdx_t;   // reg number within a thread
  typedef logic [$clog2(`RF_NTHREADS)-1:0]   threadId_t; // hardware thread number
  typedef logic [$bits(threadId_t)+$bits(regIdx_t)-1:0] rfAddr_t; // {thread, reg}

  // ==============================
  // request payloads
  // ==============================
  typedef struct packed {
    threadId_t thread; // target bank
    regIdx_t   regIdx; // target register
    value_t    data;   // value to store
  } rfWrReq_t;

  typedef struct packed {
    threadId_t thread;
    regIdx_t   regIdx;
  } rfRdReq_t;

  // handshake slave states, shared by read and write agents
  typedef enum logic [1:0] {
    Idle,  // waiting for req
    Busy,  // command taken, access in flight
    Done   // ack high until req drops
  } agentState_t;

endpackage

// ==== logic/gprRegfile.sv ====
`timescale 1ns/1ps

`include "rf_cfg.svh"

module gprRegfile import rfPkg::*; (
  input  logic    clk,
  input  logic    wrEn,    // single write port
  input  rfAddr_t wrAddr,
  input  value_t  wrData,
  input  rfAddr_t rdAddr,  // sampled on every edge
  output value_t  rdValue
);

  // ==============================
  // storage
  // ==============================
  localparam int Depth = `RF_NTHREADS * `RF_NREGS;

  // thread banks laid end to end, inferred as block ram
  value_t mem [0:Depth-1];

  rfAddr_t rdAddrQ;  // registered read address, like the bram address latch
  regIdx_t rdRegQ;   // register field of the latched address

  // write side, contents are not reset
  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrAddr] <= wrData;
    end
  end

  // read address register
  always_ff @(posedge clk) begin
    rdAddrQ <= rdAddr;
  end

  // ==============================
  // read output
  // ==============================
  // low bits of the flat address are the register number
  assign rdRegQ = rdAddrQ[$bits(regIdx_t)-1:0];

  // reg 0 of every thread reads as zero, whatever was written there
  always_comb begin
    if (rdRegQ == '0) begin
      rdValue = '0;
    end else begin
      rdValue = mem[rdAddrQ];
    end
  end

endmodule

// ==== logic/rfWriteAgent.sv ====
`timescale 1ns/1ps

module rfWriteAgent import rfPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  // four-phase slave side
  input  logic     req,
  output logic     ack,
  input  rfWrReq_t cmd,
  // toward the write arbiter
  output logic     portReq,
  output rfWrReq_t portCmd,
  input  logic     grant
);

  // ==============================
  // handshake fsm
  // ==============================
  agentState_t state;
  agentState_t stateNext;

  always_comb begin
    stateNext = state;
    case (state)
      Idle: begin
        if (req) stateNext = Busy;   // new write seen
      end
      Busy: begin
        if (grant) stateNext = Done; // storage writes on this edge
      end
      Done: begin
        if (!req) stateNext = Idle;  // master finished, drop ack
      end
      default: stateNext = Idle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= Idle;
    end else begin
      state <= stateNext;
    end
  end

  // payload latch, master keeps cmd stable but we only trust it at the first edge
  always_ff @(posedge clk) begin
    if (state == Idle && req) begin
      portCmd <= cmd;
    end
  end

  // ==============================
  // outputs
  // ==============================
  assign portReq = (state == Busy); // hold until granted
  assign ack     = (state == Done); // stays high while req is held

endmodule

// ==== logic/rfWriteArbiter.sv ====
`timescale 1ns/1ps

module rfWriteArbiter import rfPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  logic     portReq0,  // wb agent
  input  logic     portReq1,  // ld agent
  input  rfWrReq_t portCmd0,
  input  rfWrReq_t portCmd1,
  output logic     grant0,
  output logic     grant1,
  // storage write port
  output logic     wrEn,
  output rfAddr_t  wrAddr,
  output value_t   wrData
);

  // ==============================
  // round-robin grant
  // ==============================
  logic     rrPtr;  // 0: wb has priority, 1: ld has priority
  rfWrReq_t winCmd; // command of this cycle's winner

  // a lone requester always wins, ties go to the pointer
  assign grant0 = portReq0 && (!portReq1 || !rrPtr);
  assign grant1 = portReq1 && (!portReq0 ||  rrPtr);

  // pointer moves past whoever just got the port
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rrPtr <= 1'b0; // wb first after reset
    end else if (grant0) begin
      rrPtr <= 1'b1;
    end else if (grant1) begin
      rrPtr <= 1'b0;
    end
  end

  // ==============================
  // write mux
  // ==============================
  assign winCmd = grant1 ? portCmd1 : portCmd0;

  assign wrEn   = grant0 || grant1;
  assign wrAddr = {winCmd.thread, winCmd.regIdx}; // thread selects the bank
  assign wrData = winCmd.data;

endmodule

// ==== logic/rfReadAgent.sv ====
`timescale 1ns/1ps

module rfReadAgent import rfPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  // four-phase slave side
  input  logic     req,
  output logic     ack,
  input  rfRdReq_t cmd,
  // storage read port
  output rfAddr_t  rdAddr,
  input  value_t   rdValue,
  // returned value, held until the next read
  output value_t   data
);

  // ==============================
  // latency counter and fsm
  // ==============================
  // one edge for the storage address register, value taken on the one after
  localparam logic [1:0] LastWait = 2'd1;

  agentState_t state;
  logic [1:0]  waitCnt;  // edges spent in busy
  logic        lastWait; // storage output is valid this cycle

  assign lastWait = (waitCnt == LastWait);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state   <= Idle;
      waitCnt <= '0;
    end else begin
      case (state)
        Idle: begin
          if (req) begin
            state   <= Busy;
            waitCnt <= '0;
          end
        end
        Busy: begin
          if (lastWait) state <= Done;
          else          waitCnt <= waitCnt + 2'd1;
        end
        Done: begin
          if (!req) state <= Idle; // four-phase release
        end
        default: state <= Idle;
      endcase
    end
  end

  // ==============================
  // payload registers
  // ==============================
  always_ff @(posedge clk) begin
    if (state == Idle && req) begin
      rdAddr <= {cmd.thread, cmd.regIdx}; // address registered at the req edge
    end
    if (state == Busy && lastWait) begin
      data <= rdValue;                     // hold value for the master
    end
  end

  assign ack = (state == Done);

endmodule

// ==== logic/rfTop.sv ====
`timescale 1ns/1ps

module rfTop import rfPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  // execute write-back port
  input  logic     wbReq,
  output logic     wbAck,
  input  rfWrReq_t wbCmd,
  // load return port
  input  logic     ldReq,
  output logic     ldAck,
  input  rfWrReq_t ldCmd,
  // read port
  input  logic     rdReq,
  output logic     rdAck,
  input  rfRdReq_t rdCmd,
  output value_t   rdData
);

  // ==============================
  // internal wiring
  // ==============================
  logic     wbPortReq;
  rfWrReq_t wbPortCmd;
  logic     wbGrant;
  logic     ldPortReq;
  rfWrReq_t ldPortCmd;
  logic     ldGrant;

  logic     wrEn;    // from arbiter only
  rfAddr_t  wrAddr;
  value_t   wrData;
  rfAddr_t  rdAddr;  // from read agent
  value_t   rdValue;

  // ==============================
  // write side
  // ==============================
  rfWriteAgent i_wbAgent (
    .clk(clk), .arstN(arstN),
    .req(wbReq), .ack(wbAck), .cmd(wbCmd),
    .portReq(wbPortReq), .portCmd(wbPortCmd), .grant(wbGrant)
  );

  rfWriteAgent i_ldAgent (
    .clk(clk), .arstN(arstN),
    .req(ldReq), .ack(ldAck), .cmd(ldCmd),
    .portReq(ldPortReq), .portCmd(ldPortCmd), .grant(ldGrant)
  );

  rfWriteArbiter i_arb (
    .clk(clk), .arstN(arstN),
    .portReq0(wbPortReq), .portReq1(ldPortReq), // wb sits on slot 0
    .portCmd0(wbPortCmd), .portCmd1(ldPortCmd),
    .grant0(wbGrant), .grant1(ldGrant),
    .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
  );

  // ==============================
  // read side and storage
  // ==============================
  rfReadAgent i_rdAgent (
    .clk(clk), .arstN(arstN),
    .req(rdReq), .ack(rdAck), .cmd(rdCmd),
    .rdAddr(rdAddr), .rdValue(rdValue), .data(rdData)
  );

  gprRegfile i_regfile (
    .clk(clk),
    .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
    .rdAddr(rdAddr), .rdValue(rdValue)
  );

endmodule

// ==== test/rfTopTb.sv ====
`timescale 1ns/1ps

`include "rf_cfg.svh"

module rfTopTb import rfPkg::*; ();

  // ==============================
  // run constants and table
  // ==============================
  localparam int ClkPeriod   = 4;
  localparam int ResetCycles = 5;
  localparam int NumRows     = 15;
  localparam int AckLimit    = 16; // bound on one handshake
  localparam int WrLatency   = 2;  // edges from req drive to ack when uncontended
  localparam int RdLatency   = 3;

  typedef enum logic [1:0] {OpWb, OpLd, OpBoth, OpRd} op_t;

  typedef struct packed {
    op_t        op;
    threadId_t  thread;  // wb, ld or read target
    regIdx_t    regIdx;
    value_t     data;
    threadId_t  thread2; // ld target of concurrent rows
    regIdx_t    regIdx2;
    value_t     data2;
    logic [1:0] hold;    // extra cycles req stays up after ack
  } row_t;

  logic clk;
  logic arstN;
  logic wbReq, wbAck, ldReq, ldAck, rdReq, rdAck;
  rfWrReq_t wbCmd, ldCmd;
  rfRdReq_t rdCmd;
  value_t   rdData;

  row_t   rows [NumRows];
  value_t refMem [`RF_NTHREADS][`RF_NREGS]; // model of the storage
  logic   rrModel;                          // expected round-robin pointer where 0 favours wb
  int     errCount;
  int     checkCount;

  rfTop i_dut (
    .clk(clk), .arstN(arstN),
    .wbReq(wbReq), .wbAck(wbAck), .wbCmd(wbCmd),
    .ldReq(ldReq), .ldAck(ldAck), .ldCmd(ldCmd),
    .rdReq(rdReq), .rdAck(rdAck), .rdCmd(rdCmd), .rdData(rdData)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    assert (got === exp) else begin
      errCount++;
      $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic reportFault(input string msg);
    errCount++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  // step one cycle and land on the falling edge where outputs are stable
  task automatic nextCycle();
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic setRow(input int idx, input op_t op, input int t, input int r,
                        input int t2, input int r2, input int hold);
    rows[idx].op      = op;
    rows[idx].thread  = threadId_t'(t);
    rows[idx].regIdx  = regIdx_t'(r);
    rows[idx].data    = $urandom;
    rows[idx].thread2 = threadId_t'(t2);
    rows[idx].regIdx2 = regIdx_t'(r2);
    rows[idx].data2   = $urandom;
    rows[idx].hold    = 2'(hold);
  endtask

  // ==============================
  // write and read sequences
  // ==============================
  task automatic doWrite(input logic useWb, input logic useLd, input rfWrReq_t wbC,
                         input rfWrReq_t ldC, input int hold);
    int cyc;
    int wbLat;
    int ldLat;
    wbLat = 0;
    ldLat = 0;
    wbReq = useWb;
    ldReq = useLd;
    wbCmd = wbC;
    ldCmd = ldC;
    cyc = 0;
    while (((useWb && wbLat == 0) || (useLd && ldLat == 0)) && cyc < AckLimit) begin
      nextCycle();
      cyc++;
      if (wbLat == 0 && wbAck) wbLat = cyc;
      if (ldLat == 0 && ldAck) ldLat = cyc;
    end
    // the favoured port goes first and the loser of a tie waits one grant
    if (useWb) begin
      assert (wbLat != 0) else reportFault("wb port never raised its ack");
      checkEq("wbAck latency", wbLat, WrLatency + int'(useLd && rrModel));
    end
    if (useLd) begin
      assert (ldLat != 0) else reportFault("ld port never raised its ack");
      checkEq("ldAck latency", ldLat, WrLatency + int'(useWb && !rrModel));
    end
    repeat (hold) begin
      wbCmd.data = ~wbC.data; // must not be taken while ack is up
      ldCmd.data = ~ldC.data;
      nextCycle();
      if (useWb) checkEq("wbAck", 32'(wbAck), 32'd1);
      if (useLd) checkEq("ldAck", 32'(ldAck), 32'd1);
    end
    wbReq = 1'b0;
    ldReq = 1'b0;
    cyc = 0;
    while ((wbAck || ldAck) && cyc < AckLimit) begin
      nextCycle();
      cyc++;
    end
    assert (!wbAck && !ldAck) else reportFault("write ack stayed high after req fell");
    // reg 0 keeps no value in any thread
    if (useWb && wbC.regIdx != '0) refMem[wbC.thread][wbC.regIdx] = wbC.data;
    if (useLd && ldC.regIdx != '0) refMem[ldC.thread][ldC.regIdx] = ldC.data;
    if (useWb != useLd) rrModel = useWb; // lone grant moves pointer past that port
  endtask

  task automatic doRead(input threadId_t t, input regIdx_t r, input int hold);
    int     cyc;
    value_t expVal;
    expVal = refMem[t][r];
    rdReq = 1'b1;
    rdCmd.thread = t;
    rdCmd.regIdx = r;
    cyc = 0;
    while (!rdAck && cyc < AckLimit) begin
      nextCycle();
      cyc++;
    end
    assert (rdAck) else reportFault("read port never raised its ack");
    checkEq("rdAck latency", cyc, RdLatency);
    checkEq("rdData", rdData, expVal);
    repeat (hold) begin
      rdCmd.regIdx = ~r; // ignored while ack is up
      nextCycle();
      checkEq("rdAck", 32'(rdAck), 32'd1);
      checkEq("rdData", rdData, expVal);
    end
    rdReq = 1'b0;
    cyc = 0;
    while (rdAck && cyc < AckLimit) begin
      nextCycle();
      cyc++;
    end
    assert (!rdAck) else reportFault("read ack stayed high after req fell");
    checkEq("rdData", rdData, expVal); // value holds after the handshake
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    rfWrReq_t wbC;
    rfWrReq_t ldC;
    clk = 1'b0;
    arstN = 1'b0;
    wbReq = 1'b0;
    ldReq = 1'b0;
    rdReq = 1'b0;
    wbCmd = '0;
    ldCmd = '0;
    rdCmd = '0;
    errCount = 0;
    checkCount = 0;
    rrModel = 1'b0;
    void'($urandom(50));
    foreach (refMem[t, r]) refMem[t][r] = '0;
    setRow(0, OpWb, 0, 5, 0, 0, 0);
    setRow(1, OpLd, 1, 5, 0, 0, 2);    // same reg in another thread
    setRow(2, OpRd, 0, 5, 0, 0, 0);
    setRow(3, OpRd, 1, 5, 0, 0, 1);
    setRow(4, OpBoth, 2, 7, 3, 9, 0);  // wb favoured
    setRow(5, OpRd, 2, 7, 0, 0, 0);
    setRow(6, OpRd, 3, 9, 0, 0, 0);
    setRow(7, OpBoth, 0, 20, 1, 20, 1);
    setRow(8, OpWb, 3, 7, 0, 0, 3);
    setRow(9, OpBoth, 1, 0, 0, 63, 0); // ld favoured while wb hits reg 0
    setRow(10, OpRd, 0, 20, 0, 0, 0);
    setRow(11, OpRd, 3, 7, 0, 0, 0);
    setRow(12, OpRd, 1, 0, 0, 0, 2);
    setRow(13, OpRd, 0, 63, 0, 0, 0);
    setRow(14, OpRd, 1, 20, 0, 0, 0);
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    nextCycle();
    checkEq("wbAck", 32'(wbAck), 32'd0);
    checkEq("ldAck", 32'(ldAck), 32'd0);
    checkEq("rdAck", 32'(rdAck), 32'd0);
    for (int i = 0; i < NumRows; i++) begin
      wbC.thread = rows[i].thread;
      wbC.regIdx = rows[i].regIdx;
      wbC.data   = rows[i].data;
      ldC.thread = rows[i].thread2;
      ldC.regIdx = rows[i].regIdx2;
      ldC.data   = rows[i].data2;
      case (rows[i].op)
        OpWb:    doWrite(1'b1, 1'b0, wbC, '0, int'(rows[i].hold));
        OpLd:    doWrite(1'b0, 1'b1, '0, wbC, int'(rows[i].hold));
        OpBoth:  doWrite(1'b1, 1'b1, wbC, ldC, int'(rows[i].hold));
        default: doRead(rows[i].thread, rows[i].regIdx, int'(rows[i].hold));
      endcase
    end
    $display("checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog allows 40 cycles per table row
  initial begin
    #((NumRows * 40 + ResetCycles) * ClkPeriod);
    $display("TIMEOUT: run did not end within %0d cycles", NumRows * 40 + ResetCycles);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
logic/rfPkg.sv
logic/gprRegfile.sv
logic/rfWriteAgent.sv
logic/rfWriteArbiter.sv
logic/rfReadAgent.sv
logic/rfTop.sv
test/rfTopTb.sv

// ==== Makefile ====
TOP := rfTopTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "Everything OK" sim.log

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
